//--- design/decode_stage.sv
`timescale 1ns/100ps
`include "mips_cfg.svh"

module decode_stage (
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  mips_pipe_pkg::if_id_t   i_if_id,
    input  mips_pipe_pkg::wb_bus_t  i_wb,
    input  mips_isa_pkg::reg_idx_t  i_dbg_reg,
    output mips_isa_pkg::word_t     o_dbg_data,
    output mips_pipe_pkg::id_ex_t   o_id_ex
);

    mips_isa_pkg::opcode_e  opcode;
    mips_isa_pkg::reg_idx_t rs;
    mips_isa_pkg::reg_idx_t rt;
    mips_isa_pkg::imm16_t   imm;
    mips_isa_pkg::word_t    rs_data;
    mips_isa_pkg::word_t    rt_data;
    mips_pipe_pkg::id_ex_t  id_ex_d;

    // Instruction fields
    assign opcode = mips_isa_pkg::opcode_e'(i_if_id.instr[31:26]);
    assign rs     = i_if_id.instr[25:21];
    assign rt     = i_if_id.instr[20:16];
    assign imm    = i_if_id.instr[15:0];

    reg_file u_reg_file (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_rs       (rs),
        .i_rt       (rt),
        .i_wb       (i_wb),
        .i_dbg_reg  (i_dbg_reg),
        .o_rs_data  (rs_data),
        .o_rt_data  (rt_data),
        .o_dbg_data (o_dbg_data)
    );

    //////////////////////////////////////////////////
    // Control decode and immediate extension
    //////////////////////////////////////////////////

    // Invalid slot or unknown opcode leaves every write enable low.
    // I-type ops carry an equivalent funct code for the ALU control
    always_comb begin
        id_ex_d         = '0;
        id_ex_d.rs_data = rs_data;
        id_ex_d.rt_data = rt_data;
        id_ex_d.rs      = rs;
        id_ex_d.rt      = rt;
        id_ex_d.rd      = i_if_id.instr[15:11];
        id_ex_d.funct   = mips_isa_pkg::funct_e'(i_if_id.instr[5:0]);
        id_ex_d.imm     = {{(`MIPS_DATA_W-16){imm[15]}}, imm};
        if (i_if_id.valid) begin
            case (opcode)
                mips_isa_pkg::OP_RTYPE: begin
                    id_ex_d.is_rtype  = 1'b1;
                    id_ex_d.reg_dst   = 1'b1;
                    id_ex_d.reg_write = 1'b1;
                end
                mips_isa_pkg::OP_ADDI: begin
                    id_ex_d.alu_src   = 1'b1;
                    id_ex_d.reg_write = 1'b1;
                    id_ex_d.funct     = mips_isa_pkg::FN_ADD;
                end
                mips_isa_pkg::OP_ANDI, mips_isa_pkg::OP_ORI: begin
                    id_ex_d.alu_src   = 1'b1;
                    id_ex_d.reg_write = 1'b1;
                    id_ex_d.imm       = {{(`MIPS_DATA_W-16){1'b0}}, imm};
                    id_ex_d.funct     = (opcode == mips_isa_pkg::OP_ANDI) ?
                                        mips_isa_pkg::FN_AND : mips_isa_pkg::FN_OR;
                end
                mips_isa_pkg::OP_LW: begin
                    id_ex_d.alu_src   = 1'b1;
                    id_ex_d.mem_read  = 1'b1;
                    id_ex_d.reg_write = 1'b1;
                    id_ex_d.funct     = mips_isa_pkg::FN_ADD;
                end
                mips_isa_pkg::OP_SW: begin
                    id_ex_d.alu_src   = 1'b1;
                    id_ex_d.mem_write = 1'b1;
                    id_ex_d.funct     = mips_isa_pkg::FN_ADD;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_id_ex <= '0;
        end else begin
            o_id_ex <= id_ex_d;
        end
    end

endmodule

//--- design/execute_stage.sv
`timescale 1ns/100ps
`include "mips_cfg.svh"

module execute_stage (
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  mips_pipe_pkg::id_ex_t   i_id_ex,
    input  mips_pipe_pkg::wb_bus_t  i_wb,
    output mips_pipe_pkg::ex_mem_t  o_ex_mem
);

    mips_isa_pkg::fwd_sel_e fwd_a;
    mips_isa_pkg::fwd_sel_e fwd_b;
    mips_isa_pkg::word_t    op_a;
    mips_isa_pkg::word_t    rt_fwd;
    mips_isa_pkg::word_t    op_b;
    mips_isa_pkg::word_t    alu_result;
    mips_isa_pkg::alu_op_e  alu_op;
    mips_isa_pkg::reg_idx_t dest;

    //////////////////////////////////////////////////
    // Forwarding
    //////////////////////////////////////////////////

    // Younger result in EX/MEM wins over MEM/WB
    function automatic mips_isa_pkg::fwd_sel_e fwd_select(
        input mips_isa_pkg::reg_idx_t src,
        input mips_pipe_pkg::ex_mem_t mem,
        input mips_pipe_pkg::wb_bus_t wb
    );
        if (src == '0) begin
            return mips_isa_pkg::FWD_NONE;
        end else if (mem.reg_write && (mem.dest == src)) begin
            return mips_isa_pkg::FWD_MEM;
        end else if (wb.reg_write && (wb.dest == src)) begin
            return mips_isa_pkg::FWD_WB;
        end
        return mips_isa_pkg::FWD_NONE;
    endfunction

    assign fwd_a = fwd_select(i_id_ex.rs, o_ex_mem, i_wb);
    assign fwd_b = fwd_select(i_id_ex.rt, o_ex_mem, i_wb);

    assign op_a   = (fwd_a == mips_isa_pkg::FWD_MEM) ? o_ex_mem.alu_result :
                    (fwd_a == mips_isa_pkg::FWD_WB)  ? i_wb.data : i_id_ex.rs_data;
    assign rt_fwd = (fwd_b == mips_isa_pkg::FWD_MEM) ? o_ex_mem.alu_result :
                    (fwd_b == mips_isa_pkg::FWD_WB)  ? i_wb.data : i_id_ex.rt_data;
    assign op_b   = i_id_ex.alu_src ? i_id_ex.imm : rt_fwd;

    //////////////////////////////////////////////////
    // ALU control and ALU
    //////////////////////////////////////////////////
    always_comb begin
        alu_op = mips_isa_pkg::ALU_ADD;
        case (i_id_ex.funct)
            mips_isa_pkg::FN_AND: alu_op = mips_isa_pkg::ALU_AND;
            mips_isa_pkg::FN_OR:  alu_op = mips_isa_pkg::ALU_OR;
            // sub and slt only exist as R-type
            mips_isa_pkg::FN_SUB: if (i_id_ex.is_rtype) alu_op = mips_isa_pkg::ALU_SUB;
            mips_isa_pkg::FN_SLT: if (i_id_ex.is_rtype) alu_op = mips_isa_pkg::ALU_SLT;
            default: ;
        endcase
    end

    always_comb begin
        case (alu_op)
            mips_isa_pkg::ALU_SUB: alu_result = op_a - op_b;
            mips_isa_pkg::ALU_AND: alu_result = op_a & op_b;
            mips_isa_pkg::ALU_OR:  alu_result = op_a | op_b;
            mips_isa_pkg::ALU_SLT: alu_result = {{(`MIPS_DATA_W-1){1'b0}},
                                                 $signed(op_a) < $signed(op_b)};
            default:               alu_result = op_a + op_b;
        endcase
    end

    assign dest = i_id_ex.reg_dst ? i_id_ex.rd : i_id_ex.rt;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_ex_mem <= '0;
        end else begin
            o_ex_mem.alu_result <= alu_result;
            o_ex_mem.store_data <= rt_fwd;
            o_ex_mem.dest       <= dest;
            o_ex_mem.mem_read   <= i_id_ex.mem_read;
            o_ex_mem.mem_write  <= i_id_ex.mem_write;
            o_ex_mem.reg_write  <= i_id_ex.reg_write;
        end
    end

    // r0 must never pick up a result from a later stage
    a_no_fwd_r0: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        ((i_id_ex.rs != '0) || (op_a == '0)) &&
        ((i_id_ex.rt != '0) || (rt_fwd == '0)));

endmodule

//--- design/fetch_stage.sv
`timescale 1ns/100ps
`include "mips_cfg.svh"

module fetch_stage (
    input  logic                   i_clk,
    input  logic                   i_arst_n,
    input  mips_isa_pkg::word_t    i_imem_data,
    output mips_isa_pkg::word_t    o_imem_addr,
    output mips_pipe_pkg::if_id_t  o_if_id
);

    mips_isa_pkg::word_t pc;
    logic                fetched;

    assign o_imem_addr = pc;

    // Word arrives one edge after its address, so valid lags by one
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc      <= `MIPS_RESET_PC;
            fetched <= 1'b0;
            o_if_id <= '0;
        end else begin
            pc            <= pc + 32'd4;
            fetched       <= 1'b1;
            o_if_id.instr <= i_imem_data;
            o_if_id.valid <= fetched;
        end
    end

    a_pc_aligned: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        pc[1:0] == 2'b00);

endmodule

//--- design/memory_stage.sv
`timescale 1ns/100ps
`include "mips_cfg.svh"

module memory_stage (
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  mips_pipe_pkg::ex_mem_t  i_ex_mem,
    output mips_pipe_pkg::wb_bus_t  o_wb
);

    localparam int DMEM_WORDS = 2 ** `MIPS_DMEM_ADDR_W;

    mips_isa_pkg::word_t           dmem [DMEM_WORDS];
    logic [`MIPS_DMEM_ADDR_W-1:0]  word_addr;
    mips_isa_pkg::word_t           load_data;
    mips_pipe_pkg::mem_wb_t        mem_wb;

    //////////////////////////////////////////////////
    // Data memory
    //////////////////////////////////////////////////

    // Word addressed, byte offset bits dropped
    assign word_addr = i_ex_mem.alu_result[`MIPS_DMEM_ADDR_W+1:2];
    assign load_data = i_ex_mem.mem_read ? dmem[word_addr] : '0;

    always_ff @(posedge i_clk) begin
        if (i_ex_mem.mem_write) begin
            dmem[word_addr] <= i_ex_mem.store_data;
        end
    end

    //////////////////////////////////////////////////
    // MEM/WB and write-back select
    //////////////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            mem_wb <= '0;
        end else begin
            mem_wb.alu_result <= i_ex_mem.alu_result;
            mem_wb.load_data  <= load_data;
            mem_wb.dest       <= i_ex_mem.dest;
            mem_wb.mem_to_reg <= i_ex_mem.mem_read;
            mem_wb.reg_write  <= i_ex_mem.reg_write;
        end
    end

    always_comb begin
        o_wb.data      = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;
        o_wb.dest      = mem_wb.dest;
        o_wb.reg_write = mem_wb.reg_write;
    end

    a_rd_wr_excl: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(i_ex_mem.mem_read && i_ex_mem.mem_write));

endmodule

//--- design/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// Datapath and address width
`define MIPS_DATA_W 32

// Register index width, 32 general registers
`define MIPS_REG_ADDR_W 5

// Data memory depth in words, as a word-address width
`define MIPS_DMEM_ADDR_W 10

// First fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

`endif

//--- design/mips_core.sv
`timescale 1ns/100ps

module mips_core (
    input  logic                    clk,
    input  logic                    i_arst_n,
    input  mips_isa_pkg::word_t     i_imem_data,
    input  mips_isa_pkg::reg_idx_t  i_dbg_reg,
    output mips_isa_pkg::word_t     o_imem_addr,
    output mips_isa_pkg::word_t     o_dbg_data
);

    // Stage registers
    mips_pipe_pkg::if_id_t   if_id;
    mips_pipe_pkg::id_ex_t   id_ex;
    mips_pipe_pkg::ex_mem_t  ex_mem;
    // Write-back, fed back to decode and execute
    mips_pipe_pkg::wb_bus_t  wb;

    fetch_stage u_fetch (
        .i_clk       (clk),
        .i_arst_n    (i_arst_n),
        .i_imem_data (i_imem_data),
        .o_imem_addr (o_imem_addr),
        .o_if_id     (if_id)
    );

    decode_stage u_decode (
        .i_clk      (clk),
        .i_arst_n   (i_arst_n),
        .i_if_id    (if_id),
        .i_wb       (wb),
        .i_dbg_reg  (i_dbg_reg),
        .o_dbg_data (o_dbg_data),
        .o_id_ex    (id_ex)
    );

    execute_stage u_execute (
        .i_clk    (clk),
        .i_arst_n (i_arst_n),
        .i_id_ex  (id_ex),
        .i_wb     (wb),
        .o_ex_mem (ex_mem)
    );

    memory_stage u_memory (
        .i_clk    (clk),
        .i_arst_n (i_arst_n),
        .i_ex_mem (ex_mem),
        .o_wb     (wb)
    );

endmodule

//--- design/mips_isa_pkg.sv
`include "mips_cfg.svh"

package mips_isa_pkg;

    typedef logic [`MIPS_DATA_W-1:0]     word_t;
    typedef logic [`MIPS_REG_ADDR_W-1:0] reg_idx_t;
    typedef logic [15:0]                 imm16_t;

    // Primary opcode, instruction bits 31..26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_ADDI  = 6'h08,
        OP_ANDI  = 6'h0C,
        OP_ORI   = 6'h0D,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcode_e;

    // R-type function field, bits 5..0
    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2A
    } funct_e;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT} alu_op_e;

    // Operand source in EX
    typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_sel_e;

endpackage

//--- design/mips_pipe_pkg.sv
package mips_pipe_pkg;

    typedef struct packed {
        logic                valid;
        mips_isa_pkg::word_t instr;
    } if_id_t;

    // Operands, indices and controls handed from decode to execute
    typedef struct packed {
        mips_isa_pkg::word_t    rs_data;
        mips_isa_pkg::word_t    rt_data;
        mips_isa_pkg::word_t    imm;
        mips_isa_pkg::reg_idx_t rs;
        mips_isa_pkg::reg_idx_t rt;
        mips_isa_pkg::reg_idx_t rd;
        mips_isa_pkg::funct_e   funct;
        logic                   alu_src;
        logic                   reg_dst;
        logic                   is_rtype;
        logic                   mem_read;
        logic                   mem_write;
        logic                   reg_write;
    } id_ex_t;

    typedef struct packed {
        mips_isa_pkg::word_t    alu_result;
        mips_isa_pkg::word_t    store_data;
        mips_isa_pkg::reg_idx_t dest;
        logic                   mem_read;
        logic                   mem_write;
        logic                   reg_write;
    } ex_mem_t;

    typedef struct packed {
        mips_isa_pkg::word_t    alu_result;
        mips_isa_pkg::word_t    load_data;
        mips_isa_pkg::reg_idx_t dest;
        logic                   mem_to_reg;
        logic                   reg_write;
    } mem_wb_t;

    // Register write request, also the MEM/WB forwarding source
    typedef struct packed {
        mips_isa_pkg::word_t    data;
        mips_isa_pkg::reg_idx_t dest;
        logic                   reg_write;
    } wb_bus_t;

endpackage

//--- design/reg_file.sv
`timescale 1ns/100ps
`include "mips_cfg.svh"

module reg_file (
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  mips_isa_pkg::reg_idx_t  i_rs,
    input  mips_isa_pkg::reg_idx_t  i_rt,
    input  mips_pipe_pkg::wb_bus_t  i_wb,
    input  mips_isa_pkg::reg_idx_t  i_dbg_reg,
    output mips_isa_pkg::word_t     o_rs_data,
    output mips_isa_pkg::word_t     o_rt_data,
    output mips_isa_pkg::word_t     o_dbg_data
);

    localparam int NUM_REGS = 2 ** `MIPS_REG_ADDR_W;

    mips_isa_pkg::word_t regs [NUM_REGS];
    logic                wr_en;

    // r0 is hardwired and never written
    assign wr_en = i_wb.reg_write && (i_wb.dest != '0);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[i_wb.dest] <= i_wb.data;
        end
    end

    // A read in the write cycle sees the new value
    function automatic mips_isa_pkg::word_t read_port(input mips_isa_pkg::reg_idx_t idx);
        if (wr_en && (i_wb.dest == idx)) begin
            return i_wb.data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        o_rs_data = read_port(i_rs);
        o_rt_data = read_port(i_rt);
    end

    assign o_dbg_data = regs[i_dbg_reg];

endmodule

//--- dv/mips_core_tb.sv
`timescale 1ns/100ps
`include "mips_cfg.svh"

module mips_core_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int PROG_LEN     = 23;
    localparam int PAD_NOPS     = 8;
    localparam int PROG_WORDS   = 32;
    localparam int NUM_CHECKS   = 20;
    localparam int WAIT_LIMIT   = 200;

    // Last fetch address of program plus padding
    localparam mips_isa_pkg::word_t RUN_END = 32'((PROG_LEN + PAD_NOPS) * 4);

    typedef struct packed {
        mips_isa_pkg::reg_idx_t idx;
        mips_isa_pkg::word_t    val;
    } reg_exp_t;

    logic                   clk;
    logic                   i_arst_n;
    mips_isa_pkg::word_t    i_imem_data = '0;
    mips_isa_pkg::reg_idx_t i_dbg_reg;
    mips_isa_pkg::word_t    o_imem_addr;
    mips_isa_pkg::word_t    o_dbg_data;

    mips_isa_pkg::word_t    prog [PROG_WORDS];
    reg_exp_t               exp_tab [NUM_CHECKS];
    int                     word_errs = 0;
    int                     addr_errs = 0;

    mips_core dut0 (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_imem_data (i_imem_data),
        .i_dbg_reg   (i_dbg_reg),
        .o_imem_addr (o_imem_addr),
        .o_dbg_data  (o_dbg_data)
    );

    //////////////////////////////////////////////////
    // Instruction encoding
    //////////////////////////////////////////////////
    function automatic mips_isa_pkg::word_t r_type(
        input mips_isa_pkg::funct_e   fn,
        input mips_isa_pkg::reg_idx_t rd,
        input mips_isa_pkg::reg_idx_t rs,
        input mips_isa_pkg::reg_idx_t rt
    );
        return {mips_isa_pkg::OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic mips_isa_pkg::word_t i_type(
        input mips_isa_pkg::opcode_e  op,
        input mips_isa_pkg::reg_idx_t rt,
        input mips_isa_pkg::reg_idx_t rs,
        input mips_isa_pkg::imm16_t   imm
    );
        return {op, rs, rt, imm};
    endfunction

    task automatic load_program();
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = '0;
        end
        // Constants, negative addi immediate
        prog[0]  = i_type(mips_isa_pkg::OP_ADDI, 5'd1, 5'd0, 16'h0123);
        prog[1]  = i_type(mips_isa_pkg::OP_ADDI, 5'd2, 5'd0, 16'hFFF0);
        // r1 at distance 2, r2 at distance 1
        prog[2]  = r_type(mips_isa_pkg::FN_ADD, 5'd3, 5'd1, 5'd2);
        // r1 at distance 3 through the register file
        prog[3]  = r_type(mips_isa_pkg::FN_SUB, 5'd4, 5'd1, 5'd3);
        prog[4]  = r_type(mips_isa_pkg::FN_AND, 5'd5, 5'd2, 5'd3);
        prog[5]  = r_type(mips_isa_pkg::FN_OR,  5'd6, 5'd4, 5'd1);
        // Signed compare, one negative operand
        prog[6]  = r_type(mips_isa_pkg::FN_SLT, 5'd7, 5'd2, 5'd1);
        prog[7]  = r_type(mips_isa_pkg::FN_SLT, 5'd8, 5'd1, 5'd2);
        // Logical immediates with bit 15 set
        prog[8]  = i_type(mips_isa_pkg::OP_ANDI, 5'd9,  5'd2, 16'h8F0F);
        prog[9]  = i_type(mips_isa_pkg::OP_ORI,  5'd10, 5'd1, 16'h8000);
        // Write to r0, then read r0 at distances 1 and 2
        prog[10] = i_type(mips_isa_pkg::OP_ADDI, 5'd0, 5'd0, 16'h0055);
        prog[11] = r_type(mips_isa_pkg::FN_ADD, 5'd11, 5'd0, 5'd1);
        prog[12] = r_type(mips_isa_pkg::FN_OR,  5'd12, 5'd0, 5'd0);
        // Stores to three words, base forwarded
        prog[13] = i_type(mips_isa_pkg::OP_ADDI, 5'd13, 5'd0, 16'h0040);
        prog[14] = i_type(mips_isa_pkg::OP_SW,   5'd6,  5'd13, 16'h0000);
        prog[15] = i_type(mips_isa_pkg::OP_SW,   5'd10, 5'd13, 16'h0004);
        prog[16] = i_type(mips_isa_pkg::OP_ADDI, 5'd14, 5'd0, 16'h7FFF);
        prog[17] = i_type(mips_isa_pkg::OP_SW,   5'd14, 5'd13, 16'h0008);
        // Loads back into other registers
        prog[18] = i_type(mips_isa_pkg::OP_LW, 5'd15, 5'd13, 16'h0000);
        prog[19] = i_type(mips_isa_pkg::OP_LW, 5'd16, 5'd13, 16'h0004);
        prog[20] = i_type(mips_isa_pkg::OP_LW, 5'd17, 5'd13, 16'h0008);
        // Load results used at distances 2 and 3 only
        prog[21] = r_type(mips_isa_pkg::FN_ADD, 5'd18, 5'd15, 5'd16);
        prog[22] = i_type(mips_isa_pkg::OP_ADDI, 5'd19, 5'd17, 16'hFFFF);
    endtask

    // Register values worked out by hand
    task automatic load_expected();
        exp_tab[0]  = '{idx: 5'd0,  val: 32'h0000_0000};
        exp_tab[1]  = '{idx: 5'd1,  val: 32'h0000_0123};
        exp_tab[2]  = '{idx: 5'd2,  val: 32'hFFFF_FFF0};
        exp_tab[3]  = '{idx: 5'd3,  val: 32'h0000_0113};
        exp_tab[4]  = '{idx: 5'd4,  val: 32'h0000_0010};
        exp_tab[5]  = '{idx: 5'd5,  val: 32'h0000_0110};
        exp_tab[6]  = '{idx: 5'd6,  val: 32'h0000_0133};
        // -16 < 0x123 but not the other way round
        exp_tab[7]  = '{idx: 5'd7,  val: 32'h0000_0001};
        exp_tab[8]  = '{idx: 5'd8,  val: 32'h0000_0000};
        exp_tab[9]  = '{idx: 5'd9,  val: 32'h0000_8F00};
        exp_tab[10] = '{idx: 5'd10, val: 32'h0000_8123};
        exp_tab[11] = '{idx: 5'd11, val: 32'h0000_0123};
        exp_tab[12] = '{idx: 5'd12, val: 32'h0000_0000};
        exp_tab[13] = '{idx: 5'd13, val: 32'h0000_0040};
        exp_tab[14] = '{idx: 5'd14, val: 32'h0000_7FFF};
        exp_tab[15] = '{idx: 5'd15, val: 32'h0000_0133};
        exp_tab[16] = '{idx: 5'd16, val: 32'h0000_8123};
        exp_tab[17] = '{idx: 5'd17, val: 32'h0000_7FFF};
        exp_tab[18] = '{idx: 5'd18, val: 32'h0000_8256};
        exp_tab[19] = '{idx: 5'd19, val: 32'h0000_7FFE};
    endtask

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////
    task automatic check_word(
        input string               name,
        input mips_isa_pkg::word_t got,
        input mips_isa_pkg::word_t exp
    );
        if (got !== exp) begin
            word_errs++;
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_addr(
        input mips_isa_pkg::word_t got,
        input mips_isa_pkg::word_t exp
    );
        if (got !== exp) begin
            addr_errs++;
            $display("CHECK FAILED o_imem_addr: got 0x%08h, expected 0x%08h", got, exp);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Instruction memory, one cycle read latency
    always @(posedge clk) begin
        if ((o_imem_addr >> 2) < PROG_WORDS) begin
            i_imem_data <= prog[o_imem_addr[6:2]];
        end else begin
            i_imem_data <= '0;
        end
    end

    initial begin
        mips_isa_pkg::word_t exp_pc;
        int                  cycles;
        logic                timed_out;

        i_arst_n  = 1'b0;
        i_dbg_reg = '0;
        exp_pc    = `MIPS_RESET_PC;
        cycles    = 0;
        timed_out = 1'b0;
        load_program();
        load_expected();

        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_addr(o_imem_addr, `MIPS_RESET_PC);
        @(posedge clk);
        i_arst_n <= 1'b1;

        // PC steps by 4 per edge until the program has drained
        while ((o_imem_addr <= RUN_END) && !timed_out) begin
            @(negedge clk);
            check_addr(o_imem_addr, exp_pc);
            exp_pc = exp_pc + 32'd4;
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                timed_out = 1'b1;
                $display("Timeout: fetch address never passed 0x%08h", RUN_END);
            end
        end

        if (!timed_out) begin
            for (int i = 0; i < NUM_CHECKS; i++) begin
                @(posedge clk);
                i_dbg_reg <= exp_tab[i].idx;
                @(negedge clk);
                check_word($sformatf("o_dbg_data r%0d", exp_tab[i].idx), o_dbg_data,
                           exp_tab[i].val);
            end
        end

        $display("Errors: %0d register value, %0d fetch address, %0d timeout",
                 word_errs, addr_errs, timed_out);
        if (timed_out || (word_errs + addr_errs) != 0) begin
            $display("Verification failed");
        end else begin
            $display("Verification passed");
        end
        $finish;
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the MIPS pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module mips_core_tb

output=$(./obj_dir/Vmips_core_tb)
echo "$output"

if echo "$output" | grep -qx "Verification passed"; then
    exit 0
else
    exit 1
fi

//--- verilog.f
+incdir+design
design/mips_isa_pkg.sv
design/mips_pipe_pkg.sv
design/fetch_stage.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/mips_core.sv
dv/mips_core_tb.sv
